// File: bench/tb_ex_tasks.svh
// CP0 register number sits in bits 15:11
function automatic cpu_pkg::word_t cp0_sel(input int unsigned num);
	return 32'(num) << 11;
endfunction

task automatic queue_inst(input cpu_pkg::oper_t op, input cpu_pkg::word_t reg1,
	input cpu_pkg::word_t reg2, input cpu_pkg::word_t imm, input cpu_pkg::word_t pc,
	input cpu_pkg::word_t inst);
	cpu_pkg::ex_in_t x;
	x.op   = op;
	x.pc   = pc;
	x.inst = inst;
	x.reg1 = reg1;
	x.reg2 = reg2;
	x.imm  = imm;
	send_q.push_back(x);
endtask

// Called on a rising edge, returns on the edge of the transfer
task automatic issue_inst(input cpu_pkg::ex_in_t inst);
	in_data  <= inst;
	in_valid <= 1'b1;
	@(negedge clk);
	while (!in_ready)
		@(negedge clk);
	@(posedge clk);
endtask

task automatic get_result(output cpu_pkg::ex_out_t res);
	logic done;
	done = 1'b0;
	while (!done)
	begin
		out_ready <= stall_en ? ($urandom % 3 != 0) : 1'b1;
		@(negedge clk);
		if (out_valid && out_ready)
		begin
			res  = out_data;
			done = 1'b1;
		end
		@(posedge clk);
	end
endtask

// Issue and collect run side by side so the stream has no gaps
task automatic run_batch();
	int n;
	cpu_pkg::ex_out_t r;
	n = send_q.size();
	recv_q.delete();
	@(posedge clk);
	fork
		begin
			foreach (send_q[i])
				issue_inst(send_q[i]);
			in_valid <= 1'b0;
		end
		begin
			repeat (n)
			begin
				get_result(r);
				recv_q.push_back(r);
			end
		end
	join
	send_q.delete();
endtask

task automatic report_mismatch(input string name, input cpu_pkg::word_t expected,
	input cpu_pkg::word_t actual);
	$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
	test_errs++;
endtask

task automatic finish_test(input string name);
	if (test_errs == 0)
	begin
		$display("[PASS] %s", name);
		pass_count++;
	end
	else
	begin
		$display("%s finished with %0d mismatches", name, test_errs);
		fail_count++;
	end
	test_errs = 0;
endtask

task automatic reset_state();
	@(negedge clk);
	if (in_ready !== 1'b1)
		report_mismatch("reset_state", 32'd1, 32'(in_ready));
	if (out_valid !== 1'b0)
		report_mismatch("reset_state", 32'd0, 32'(out_valid));
	if (out_data.except.occur !== 1'b0)
		report_mismatch("reset_state", 32'd0, 32'(out_data.except.occur));
	finish_test("reset_state");
endtask

task automatic arith_ops();
	cpu_pkg::word_t r1[4];
	cpu_pkg::word_t im[4];
	cpu_pkg::word_t pc[4];
	for (int i = 0; i < 4; i++)
	begin
		r1[i] = $urandom;
		im[i] = $urandom & 32'h0000ffff; // Zero-extended immediate
		pc[i] = $urandom & 32'hfffffffc;
		queue_inst(cpu_pkg::OP_ORI, r1[i], '0, im[i], '0, '0);
		queue_inst(cpu_pkg::OP_JAL, '0, '0, '0, pc[i], '0);
	end
	run_batch();
	for (int i = 0; i < 4; i++)
	begin
		if (recv_q[2*i].ret !== (r1[i] | im[i]))
			report_mismatch("arith", r1[i] | im[i], recv_q[2*i].ret);
		if (recv_q[2*i+1].ret !== pc[i] + 32'd8)
			report_mismatch("arith", pc[i] + 32'd8, recv_q[2*i+1].ret);
	end
	finish_test("arith");
endtask

task automatic hilo_forwarding();
	cpu_pkg::word_t a;
	cpu_pkg::word_t b;
	a = $urandom;
	b = $urandom;
	queue_inst(cpu_pkg::OP_MTHI, a, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MTLO, b, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MFHI, '0, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MFLO, '0, '0, '0, '0, '0);
	run_batch();
	if (recv_q[2].ret !== a)
		report_mismatch("hilo_forward", a, recv_q[2].ret);
	if (recv_q[3].ret !== b)
		report_mismatch("hilo_forward", b, recv_q[3].ret);
	finish_test("hilo_forward");
endtask

task automatic maddu_accumulate();
	cpu_pkg::word_t x1;
	cpu_pkg::word_t y1;
	cpu_pkg::word_t x2;
	cpu_pkg::word_t y2;
	logic [63:0]    sum;
	x1  = $urandom;
	y1  = $urandom;
	x2  = $urandom;
	y2  = $urandom;
	sum = 64'(x1) * 64'(y1) + 64'(x2) * 64'(y2); // Unsigned products
	queue_inst(cpu_pkg::OP_MTHI, '0, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MTLO, '0, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MADDU, x1, y1, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MADDU, x2, y2, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MFHI, '0, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MFLO, '0, '0, '0, '0, '0);
	run_batch();
	if (recv_q[4].ret !== sum[63:32])
		report_mismatch("maddu_acc", sum[63:32], recv_q[4].ret);
	if (recv_q[5].ret !== sum[31:0])
		report_mismatch("maddu_acc", sum[31:0], recv_q[5].ret);
	finish_test("maddu_acc");
endtask

task automatic mem_request();
	cpu_pkg::word_t r1;
	cpu_pkg::word_t r2;
	cpu_pkg::word_t im;
	logic [5:0]     flags;
	r1 = $urandom;
	r2 = $urandom;
	im = $urandom;
	queue_inst(cpu_pkg::OP_LW, r1, r2, im, '0, '0);
	queue_inst(cpu_pkg::OP_SW, r1, r2, im, '0, '0);
	queue_inst(cpu_pkg::OP_ORI, r1, r2, im, '0, '0);
	run_batch();
	for (int i = 0; i < 2; i++)
	begin
		flags = {recv_q[i].memory_req.ce, recv_q[i].memory_req.we, recv_q[i].memory_req.sel};
		if (recv_q[i].memory_req.addr !== r1 + im)
			report_mismatch("mem_req", r1 + im, recv_q[i].memory_req.addr);
		if (recv_q[i].memory_req.wdata !== r2)
			report_mismatch("mem_req", r2, recv_q[i].memory_req.wdata);
		if (flags !== {1'b1, i == 1, 4'hf}) // ce, we, sel
			report_mismatch("mem_req", 32'({1'b1, i == 1, 4'hf}), 32'(flags));
	end
	if (recv_q[2].memory_req.ce !== 1'b0)
		report_mismatch("mem_req", 32'd0, 32'(recv_q[2].memory_req.ce));
	finish_test("mem_req");
endtask

task automatic cp0_traps();
	cpu_pkg::word_t v;
	cpu_pkg::word_t p;
	cpu_pkg::word_t k;
	v = $urandom;
	p = $urandom & 32'hfffffffc;
	k = $urandom;
	queue_inst(cpu_pkg::OP_MTC0, '0, v, '0, '0, cp0_sel(14));
	queue_inst(cpu_pkg::OP_MFC0, '0, '0, '0, '0, cp0_sel(14));
	queue_inst(cpu_pkg::OP_TEQI, k, '0, k, p, '0);
	queue_inst(cpu_pkg::OP_MFC0, '0, '0, '0, '0, cp0_sel(13));
	queue_inst(cpu_pkg::OP_MFC0, '0, '0, '0, '0, cp0_sel(14));
	queue_inst(cpu_pkg::OP_MFC0, '0, '0, '0, '0, cp0_sel(12));
	queue_inst(cpu_pkg::OP_ERET, '0, '0, '0, '0, '0);
	queue_inst(cpu_pkg::OP_MFC0, '0, '0, '0, '0, cp0_sel(12));
	queue_inst(cpu_pkg::OP_TEQI, k, '0, k ^ 32'd1, '0, '0);
	run_batch();
	if (recv_q[1].ret !== v)
		report_mismatch("cp0_trap", v, recv_q[1].ret);
	if (recv_q[2].except !== {1'b1, 1'b0, 5'd13}) // occur, eret, code
		report_mismatch("cp0_trap", 32'({1'b1, 1'b0, 5'd13}), 32'(recv_q[2].except));
	if (recv_q[2].pc !== p)
		report_mismatch("cp0_trap", p, recv_q[2].pc);
	if (recv_q[3].ret[6:2] !== 5'd13)
		report_mismatch("cp0_trap", 32'd13, 32'(recv_q[3].ret[6:2]));
	if (recv_q[4].ret !== p)
		report_mismatch("cp0_trap", p, recv_q[4].ret);
	if (recv_q[5].ret[1] !== 1'b1)
		report_mismatch("cp0_trap", 32'd1, 32'(recv_q[5].ret[1]));
	if ({recv_q[6].except.occur, recv_q[6].except.eret} !== 2'b11)
		report_mismatch("cp0_trap", 32'd3, 32'({recv_q[6].except.occur, recv_q[6].except.eret}));
	if (recv_q[7].ret[1] !== 1'b0)
		report_mismatch("cp0_trap", 32'd0, 32'(recv_q[7].ret[1]));
	if (recv_q[8].except.occur !== 1'b0)
		report_mismatch("cp0_trap", 32'd0, 32'(recv_q[8].except.occur));
	finish_test("cp0_trap");
endtask

task automatic back_pressure();
	cpu_pkg::word_t r1[20];
	cpu_pkg::word_t im[20];
	for (int i = 0; i < 20; i++)
	begin
		r1[i] = $urandom;
		im[i] = $urandom & 32'h0000ffff;
		queue_inst(cpu_pkg::OP_ORI, r1[i], '0, im[i], '0, '0);
	end
	stall_en = 1'b1;
	run_batch();
	stall_en = 1'b0;
	for (int i = 0; i < 20; i++)
	begin
		if (recv_q[i].ret !== (r1[i] | im[i]))
			report_mismatch("back_pressure", r1[i] | im[i], recv_q[i].ret);
	end
	@(negedge clk);
	if (out_valid)
	begin
		$display("back_pressure: a result is still offered after the last expected one");
		test_errs++;
	end
	finish_test("back_pressure");
endtask

// File: bench/tb_ex_cluster.sv
`timescale 1ns/1ns

module tb_ex_cluster;

	localparam int CLK_HALF   = 50;
	localparam int MAX_CYCLES = 2000; // Bound on the whole test sequence

	logic             clk;
	logic             rst;
	cpu_pkg::ex_in_t  in_data;
	logic             in_valid;
	logic             in_ready;
	cpu_pkg::ex_out_t out_data;
	logic             out_valid;
	logic             out_ready;

	cpu_pkg::ex_in_t  send_q[$]; // Instructions for the next batch
	cpu_pkg::ex_out_t recv_q[$]; // Results of the last batch, in order
	logic             stall_en;
	int               test_errs;
	int               pass_count;
	int               fail_count;
	int               cycle_count = 0;

	ex_cluster dut0
	(
		.clk       (clk),
		.rst       (rst),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	`include "tb_ex_tasks.svh"

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#CLK_HALF clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(87));
		rst        <= 1'b1;
		in_data    <= '0;
		in_valid   <= 1'b0;
		out_ready  <= 1'b1;
		stall_en   = 1'b0;
		test_errs  = 0;
		pass_count = 0;
		fail_count = 0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		reset_state();
		arith_ops();
		hilo_forwarding();
		maddu_accumulate();
		mem_request();
		cp0_traps();
		back_pressure();

		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: logic/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs
(
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_pkg::reg_addr_t      raddr,
	output cpu_pkg::word_t          rdata,
	input  cpu_pkg::reg_write_req_t wr,
	input  cpu_pkg::except_info_t   except,
	input  cpu_pkg::word_t          epc_pc,
	input  logic                    commit
);

	cpu_pkg::word_t status;
	cpu_pkg::word_t cause;
	cpu_pkg::word_t epc;
	cpu_pkg::word_t status_next;
	cpu_pkg::word_t cause_next;
	cpu_pkg::word_t epc_next;

	always_comb
	begin
		status_next = status;
		cause_next  = cause;
		epc_next    = epc;
		if (commit)
		begin
			if (wr.we && wr.waddr == cpu_pkg::CP0_STATUS)
			begin
				status_next = wr.wdata;
			end
			if (wr.we && wr.waddr == cpu_pkg::CP0_EPC)
			begin
				epc_next = wr.wdata;
			end
			if (except.occur && !except.eret)
			begin
				epc_next = epc_pc;
				cause_next[cpu_pkg::CAUSE_EXC_LSB +: cpu_pkg::EXCCODE_W] = except.code;
				status_next[cpu_pkg::STATUS_EXL] = 1'b1;
			end
			if (except.occur && except.eret)
			begin
				status_next[cpu_pkg::STATUS_EXL] = 1'b0;
			end
		end
	end

	// Reads already include whatever the draining latch commits
	always_comb
	begin
		case (raddr)
			cpu_pkg::CP0_STATUS: rdata = status_next;
			cpu_pkg::CP0_CAUSE:  rdata = cause_next;
			cpu_pkg::CP0_EPC:    rdata = epc_next;
			default:             rdata = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			status <= '0;
			cause  <= '0;
			epc    <= '0;
		end
		else
		begin
			status <= status_next;
			cause  <= cause_next;
			epc    <= epc_next;
		end
	end

endmodule

// File: logic/cpu_ex.sv
`timescale 1ns/1ns

module cpu_ex
(
	input  logic                     clk,
	input  logic                     rst,

	input  cpu_pkg::ex_in_t          ex_inst,
	input  logic                     ex_valid,

	input  cpu_pkg::dword_t          hilo_unsafe,
	input  cpu_pkg::word_t           cp0_rdata_unsafe,
	input  cpu_pkg::hilo_write_req_t mem_hilo_wr,
	input  cpu_pkg::reg_write_req_t  mem_cp0_reg_wr,

	output cpu_pkg::reg_addr_t       cp0_raddr,
	output cpu_pkg::hilo_write_req_t hilo_wr,
	output cpu_pkg::reg_write_req_t  cp0_reg_wr,
	output cpu_pkg::ex_out_t         result,
	output logic                     stall_req
);

	cpu_pkg::dword_t hilo_safe;
	cpu_pkg::word_t  hi;
	cpu_pkg::word_t  lo;
	cpu_pkg::word_t  cp0_rdata_safe;
	cpu_pkg::dword_t multi_cyc_ret;
	logic            is_mem;
	logic            we_hilo;

	// Pending HI/LO write in the latch wins
	assign hilo_safe = mem_hilo_wr.we ? mem_hilo_wr.hilo : hilo_unsafe;
	assign {hi, lo}  = hilo_safe;

	assign cp0_raddr = ex_inst.inst[15:11];
	assign cp0_rdata_safe = (mem_cp0_reg_wr.we && mem_cp0_reg_wr.waddr == cp0_raddr) ?
		mem_cp0_reg_wr.wdata : cp0_rdata_unsafe;

	assign cp0_reg_wr.we    = ex_valid && ex_inst.op == cpu_pkg::OP_MTC0;
	assign cp0_reg_wr.waddr = ex_inst.inst[15:11];
	assign cp0_reg_wr.wdata = ex_inst.reg2;

	ex_multi_cyc multi_cyc0
	(
		.clk   (clk),
		.rst   (rst),
		.op    (ex_inst.op),
		.start (ex_valid),
		.reg1  (ex_inst.reg1),
		.reg2  (ex_inst.reg2),
		.hilo  (hilo_safe),
		.ret   (multi_cyc_ret),
		.busy  (stall_req)
	);

	assign is_mem = ex_inst.op == cpu_pkg::OP_LW || ex_inst.op == cpu_pkg::OP_SW;

	assign result.pc                = ex_inst.pc;
	assign result.memory_req.ce     = ex_valid && is_mem;
	assign result.memory_req.we     = ex_valid && ex_inst.op == cpu_pkg::OP_SW;
	assign result.memory_req.addr   = ex_inst.reg1 + ex_inst.imm;
	assign result.memory_req.wdata  = ex_inst.reg2;
	assign result.memory_req.sel    = is_mem ? cpu_pkg::SEL_WORD : '0;

	always_comb
	begin
		result.except = '0;
		if (ex_valid && ex_inst.op == cpu_pkg::OP_TEQI && ex_inst.reg1 == ex_inst.imm)
		begin
			result.except.occur = 1'b1;
			result.except.code  = cpu_pkg::EXCCODE_TR;
		end
		if (ex_valid && ex_inst.op == cpu_pkg::OP_ERET)
		begin
			result.except.occur = 1'b1;
			result.except.eret  = 1'b1;
		end
	end

	assign we_hilo = ex_inst.op == cpu_pkg::OP_MTHI || ex_inst.op == cpu_pkg::OP_MTLO ||
		ex_inst.op == cpu_pkg::OP_MADDU;
	assign hilo_wr.we = ex_valid && we_hilo;

	always_comb
	begin
		result.ret   = '0;
		hilo_wr.hilo = hilo_safe;
		case (ex_inst.op)
			cpu_pkg::OP_ORI:   result.ret = ex_inst.reg1 | ex_inst.imm;
			cpu_pkg::OP_JAL:   result.ret = ex_inst.pc + cpu_pkg::JAL_LINK_OFFSET;
			cpu_pkg::OP_MFHI:  result.ret = hi;
			cpu_pkg::OP_MFLO:  result.ret = lo;
			cpu_pkg::OP_MFC0:  result.ret = cp0_rdata_safe;
			cpu_pkg::OP_MTHI:  hilo_wr.hilo = {ex_inst.reg1, lo};
			cpu_pkg::OP_MTLO:  hilo_wr.hilo = {hi, ex_inst.reg1};
			cpu_pkg::OP_MADDU: hilo_wr.hilo = multi_cyc_ret;
			default:           result.ret = '0;
		endcase
	end

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W     = 32;
	localparam int DWORD_W    = 2 * WORD_W;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W       = 4;
	localparam int MC_W       = 2;
	localparam int SEL_W      = 4;
	localparam int EXCCODE_W  = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [DWORD_W-1:0]    dword_t; // HI in upper half
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [OP_W-1:0] {
		OP_NOP,
		OP_ORI,
		OP_JAL,
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO,
		OP_MADDU,
		OP_LW,
		OP_SW,
		OP_MFC0,
		OP_MTC0,
		OP_TEQI,
		OP_ERET
	} oper_t;

	typedef enum logic [MC_W-1:0] {
		MC_IDLE,
		MC_MUL,
		MC_ACC,
		MC_DONE
	} mc_state_t;

	typedef struct packed {
		oper_t op;
		word_t pc;
		word_t inst;
		word_t reg1;
		word_t reg2;
		word_t imm;
	} ex_in_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_write_req_t;

	typedef struct packed {
		logic   we;
		dword_t hilo;
	} hilo_write_req_t;

	typedef struct packed {
		logic             ce;
		logic             we;
		word_t            addr;
		word_t            wdata;
		logic [SEL_W-1:0] sel;
	} mem_access_req_t;

	typedef struct packed {
		logic                 occur;
		logic                 eret;
		logic [EXCCODE_W-1:0] code;
	} except_info_t;

	typedef struct packed {
		word_t           pc;
		word_t           ret;
		mem_access_req_t memory_req;
		except_info_t    except;
	} ex_out_t;

	localparam reg_addr_t CP0_STATUS = 5'd12;
	localparam reg_addr_t CP0_CAUSE  = 5'd13;
	localparam reg_addr_t CP0_EPC    = 5'd14;

	localparam int STATUS_EXL    = 1;
	localparam int CAUSE_EXC_LSB = 2; // Code field is bits 6:2

	localparam logic [EXCCODE_W-1:0] EXCCODE_TR = 5'd13;
	localparam word_t JAL_LINK_OFFSET = 32'd8;
	localparam logic [SEL_W-1:0] SEL_WORD = 4'b1111;

endpackage

// File: logic/ex_cluster.sv
`timescale 1ns/1ns

module ex_cluster
(
	input  logic              clk,
	input  logic              rst,

	input  cpu_pkg::ex_in_t   in_data,
	input  logic              in_valid,
	output logic              in_ready,

	output cpu_pkg::ex_out_t  out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	cpu_pkg::ex_in_t          ex_inst;
	logic                     ex_valid;
	logic                     advance;
	logic                     commit;
	logic                     stall_req;
	cpu_pkg::dword_t          hilo;
	cpu_pkg::word_t           cp0_rdata;
	cpu_pkg::reg_addr_t       cp0_raddr;
	cpu_pkg::hilo_write_req_t hilo_wr;
	cpu_pkg::reg_write_req_t  cp0_reg_wr;
	cpu_pkg::ex_out_t         result;
	cpu_pkg::hilo_write_req_t mem_hilo_wr;
	cpu_pkg::reg_write_req_t  mem_cp0_reg_wr;

	ex_issue_ctrl issue_ctrl0
	(
		.clk       (clk),
		.rst       (rst),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.stall_req (stall_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.ex_inst   (ex_inst),
		.ex_valid  (ex_valid),
		.advance   (advance),
		.commit    (commit)
	);

	cpu_ex ex0
	(
		.clk              (clk),
		.rst              (rst),
		.ex_inst          (ex_inst),
		.ex_valid         (ex_valid),
		.hilo_unsafe      (hilo),
		.cp0_rdata_unsafe (cp0_rdata),
		.mem_hilo_wr      (mem_hilo_wr),
		.mem_cp0_reg_wr   (mem_cp0_reg_wr),
		.cp0_raddr        (cp0_raddr),
		.hilo_wr          (hilo_wr),
		.cp0_reg_wr       (cp0_reg_wr),
		.result           (result),
		.stall_req        (stall_req)
	);

	// CP0 updates come from the committing latch entry
	cp0_regs cp0_0
	(
		.clk    (clk),
		.rst    (rst),
		.raddr  (cp0_raddr),
		.rdata  (cp0_rdata),
		.wr     (mem_cp0_reg_wr),
		.except (out_data.except),
		.epc_pc (out_data.pc),
		.commit (commit)
	);

	ex_commit commit0
	(
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.commit         (commit),
		.result_in      (result),
		.hilo_wr_in     (hilo_wr),
		.cp0_wr_in      (cp0_reg_wr),
		.out_data       (out_data),
		.out_valid      (out_valid),
		.hilo           (hilo),
		.mem_hilo_wr    (mem_hilo_wr),
		.mem_cp0_reg_wr (mem_cp0_reg_wr)
	);

endmodule

// File: logic/ex_commit.sv
`timescale 1ns/1ns

module ex_commit
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     advance,
	input  logic                     commit,

	input  cpu_pkg::ex_out_t         result_in,
	input  cpu_pkg::hilo_write_req_t hilo_wr_in,
	input  cpu_pkg::reg_write_req_t  cp0_wr_in,

	output cpu_pkg::ex_out_t         out_data,
	output logic                     out_valid,
	output cpu_pkg::dword_t          hilo,
	output cpu_pkg::hilo_write_req_t mem_hilo_wr,
	output cpu_pkg::reg_write_req_t  mem_cp0_reg_wr
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid         <= 1'b0;
			out_data.except   <= '0;
			mem_hilo_wr.we    <= 1'b0;
			mem_cp0_reg_wr.we <= 1'b0;
		end
		else if (advance)
		begin
			out_valid      <= 1'b1; // Load overrides a same-cycle drain
			out_data       <= result_in;
			mem_hilo_wr    <= hilo_wr_in;
			mem_cp0_reg_wr <= cp0_wr_in;
		end
		else if (commit)
		begin
			out_valid         <= 1'b0;
			mem_hilo_wr.we    <= 1'b0;
			mem_cp0_reg_wr.we <= 1'b0;
		end
	end

	// HI/LO only changes when its writer leaves the latch
	always_ff @(posedge clk)
	begin
		if (commit && mem_hilo_wr.we)
		begin
			hilo <= mem_hilo_wr.hilo;
		end
	end

endmodule

// File: logic/ex_issue_ctrl.sv
`timescale 1ns/1ns

module ex_issue_ctrl
(
	input  logic            clk,
	input  logic            rst,

	input  cpu_pkg::ex_in_t in_data,
	input  logic            in_valid,
	output logic            in_ready,

	input  logic            stall_req,
	input  logic            out_valid,
	input  logic            out_ready,

	output cpu_pkg::ex_in_t ex_inst,
	output logic            ex_valid,
	output logic            advance,
	output logic            commit
);

	logic accept;
	logic latch_free;

	// Latch can take a new result this cycle
	assign commit     = out_valid && out_ready;
	assign latch_free = !out_valid || commit;

	assign advance  = ex_valid && !stall_req && latch_free;
	assign in_ready = !ex_valid || advance;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_valid <= 1'b0;
		end
		else if (accept)
		begin
			ex_valid <= 1'b1;
		end
		else if (advance)
		begin
			ex_valid <= 1'b0; // Slot drained, nothing new
		end
	end

	// Instruction held until it advances
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			ex_inst <= in_data;
		end
	end

endmodule

// File: logic/ex_multi_cyc.sv
`timescale 1ns/1ns

module ex_multi_cyc
(
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::oper_t    op,
	input  logic              start,
	input  cpu_pkg::word_t    reg1,
	input  cpu_pkg::word_t    reg2,
	input  cpu_pkg::dword_t   hilo,
	output cpu_pkg::dword_t   ret,
	output logic              busy
);

	cpu_pkg::mc_state_t state;
	cpu_pkg::mc_state_t cur;
	cpu_pkg::dword_t    prod;
	cpu_pkg::dword_t    acc;
	logic               go;

	assign go = start && op == cpu_pkg::OP_MADDU;

	// A new MADDU enters the multiply step in its first slot cycle
	assign cur  = (state == cpu_pkg::MC_IDLE && go) ? cpu_pkg::MC_MUL : state;
	assign busy = cur == cpu_pkg::MC_MUL || cur == cpu_pkg::MC_ACC;
	assign ret  = acc;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= cpu_pkg::MC_IDLE;
		end
		else
		begin
			case (cur)
				cpu_pkg::MC_MUL:  state <= cpu_pkg::MC_ACC;
				cpu_pkg::MC_ACC:  state <= cpu_pkg::MC_DONE;
				default:          state <= cpu_pkg::MC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (cur == cpu_pkg::MC_MUL)
		begin
			prod <= cpu_pkg::dword_t'(reg1) * cpu_pkg::dword_t'(reg2); // Unsigned 32x32
		end
		if (cur == cpu_pkg::MC_ACC)
		begin
			acc <= prod + hilo; // HI/LO already forwarded
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; status is set by the pass message in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ex_cluster -f sources.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

// File: sources.f
+incdir+bench
logic/cpu_pkg.sv
logic/ex_issue_ctrl.sv
logic/ex_multi_cyc.sv
logic/cpu_ex.sv
logic/cp0_regs.sv
logic/ex_commit.sv
logic/ex_cluster.sv
bench/tb_ex_cluster.sv
